// ==== build.f ====
+incdir+include
design/fpu_pkg.sv
design/fpu_add.sv
design/fpu_mult.sv
design/fpu_norm.sv
design/fpu_ctrl.sv
design/fpu_top.sv
verif/fpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the FPU testbench
VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= >>> PASS

BIN  := $(OBJ_DIR)/$(TOP)
SRCS := $(wildcard design/*.sv verif/*.sv include/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== include/fpu_vectors.svh ====
`ifndef FPU_VECTORS_SVH
`define FPU_VECTORS_SVH

// Columns: name, op, a, b, expected result word, expected {ovf, uf, inexact}
typedef struct packed
{
   logic [8*16-1:0]  name;
   fpu_pkg::fpu_op_e op;
   logic [31:0]      a;
   logic [31:0]      b;
   logic [31:0]      result;
   logic [2:0]       flags;
} test_vec_t;

test_vec_t vec_table [20] = '{
   // Same-sign add, alignment and ties
   '{"add_basic",    fpu_pkg::OP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000, 3'b000},
   '{"add_tie_even", fpu_pkg::OP_ADD, 32'h3F800000, 32'h33800000, 32'h3F800000, 3'b001},
   '{"add_tie_up",   fpu_pkg::OP_ADD, 32'h3F800001, 32'h33800000, 32'h3F800002, 3'b001},
   '{"add_far",      fpu_pkg::OP_ADD, 32'h3F800000, 32'h30800000, 32'h3F800000, 3'b001},
   // Cancellation gives +0
   '{"sub_cancel",   fpu_pkg::OP_SUB, 32'h3F800000, 32'h3F800000, 32'h00000000, 3'b000},
   '{"add_cancel",   fpu_pkg::OP_ADD, 32'h40200000, 32'hC0200000, 32'h00000000, 3'b000},
   // Sign of the larger magnitude
   '{"sub_neg",      fpu_pkg::OP_SUB, 32'h3F800000, 32'h40400000, 32'hC0000000, 3'b000},
   '{"add_mixed",    fpu_pkg::OP_ADD, 32'hC0A00000, 32'h3FA00000, 32'hC0700000, 3'b000},
   '{"sub_eq_exp",   fpu_pkg::OP_SUB, 32'h40400000, 32'h40200000, 32'h3F000000, 3'b000},
   '{"sub_far",      fpu_pkg::OP_SUB, 32'h3F800000, 32'h30800000, 32'h3F800000, 3'b001},
   // Products, rounding from the low bits
   '{"mul_basic",    fpu_pkg::OP_MUL, 32'h3FC00000, 32'hC0200000, 32'hC0700000, 3'b000},
   '{"mul_carry",    fpu_pkg::OP_MUL, 32'h3FC00000, 32'h3FC00000, 32'h40100000, 3'b000},
   '{"mul_sticky",   fpu_pkg::OP_MUL, 32'h3F800001, 32'h3F800001, 32'h3F800002, 3'b001},
   '{"mul_tie_up",   fpu_pkg::OP_MUL, 32'h3FC00000, 32'h3F800001, 32'h3FC00002, 3'b001},
   '{"mul_zero",     fpu_pkg::OP_MUL, 32'hC0400000, 32'h00000000, 32'h80000000, 3'b000},
   // Overflow to infinity
   '{"mul_ovf",      fpu_pkg::OP_MUL, 32'h7F7FFFFF, 32'h40000000, 32'h7F800000, 3'b101},
   '{"mul_ovf_neg",  fpu_pkg::OP_MUL, 32'hFF7FFFFF, 32'h40000000, 32'hFF800000, 3'b101},
   '{"add_ovf",      fpu_pkg::OP_ADD, 32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, 3'b101},
   // Underflow flushed to signed zero
   '{"mul_uf",       fpu_pkg::OP_MUL, 32'h00800000, 32'h3F000000, 32'h00000000, 3'b011},
   '{"mul_uf_neg",   fpu_pkg::OP_MUL, 32'h80800000, 32'h3F000000, 32'h80000000, 3'b011}
};

`endif

// ==== verif/fpu_tb.sv ====
`default_nettype none

module fpu_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_HALF        = 10;
   localparam int RESET_CYCLES    = 10;
   localparam int NUM_RANDOM      = 60;
   localparam int CYCLES_PER_TEST = 40;

   logic               clk;
   logic               rst_n;
   logic               req;
   fpu_pkg::fpu_req_t  req_data;
   logic               ack;
   fpu_pkg::fpu_resp_t resp;

   // Error counters
   int                 mismatches       = 0;
   int                 handshake_errors = 0;
   int                 timeouts         = 0;
   logic [31:0]        lcg_state;

   `include "fpu_vectors.svh"

   fpu_top u_fpu_top
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .req_data (req_data),
      .ack      (ack),
      .resp     (resp)
   );

   // 20 ns period
   always #(CLK_HALF) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Reference helpers
   ////////////////////////////////////////////////////////////////////////////

   // LCG step, folded into -4096..4096
   function automatic int draw_operand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'((lcg_state >> 16) % 32'd8193) - 4096;
   endfunction

   // Exact integer to binary32, magnitudes up to 2^24
   function automatic logic [31:0] int_to_f32(input int value);
      logic        sign;
      int          mag;
      int          msb;
      logic [31:0] frac_full;
      if (value == 0)
         return 32'h0000_0000;
      sign = (value < 0);
      mag  = sign ? -value : value;
      msb  = 0;
      for (int i = 0; i < 31; i++)
      begin
         if (mag[i])
            msb = i;
      end
      // Leading one to bit 23, dropped as the hidden bit
      if (msb <= 23)
         frac_full = 32'(mag) << (23 - msb);
      else
         frac_full = 32'(mag) >> (msb - 23);
      return {sign, 8'(127 + msb), frac_full[22:0]};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Requester and checks
   ////////////////////////////////////////////////////////////////////////////

   // Full four-phase cycle, called and returning on a falling edge
   task automatic send_request
   (
      input  string              name,
      input  fpu_pkg::fpu_req_t  data,
      input  int                 hold_cycles,
      output fpu_pkg::fpu_resp_t got
   );
      fpu_pkg::fpu_resp_t first;
      int                 latency;
      int                 release_cycles;
      req_data = data;
      req      = 1'b1;
      latency  = 0;
      // Watchdog covers a missing ack
      while (!ack)
      begin
         @(negedge clk);
         latency++;
      end
      // Edge that samples req, then one cycle to ack
      assert (latency == 2)
      else
      begin
         handshake_errors++;
         $display("handshake error in %0s: ack after %0d cycles instead of 2", name, latency);
      end
      first = resp;
      // Back-pressure, ack and resp must hold
      repeat (hold_cycles)
      begin
         @(negedge clk);
         assert (ack && resp == first)
         else
         begin
            handshake_errors++;
            $display("handshake error in %0s: ack or resp moved while req was held", name);
         end
      end
      req            = 1'b0;
      release_cycles = 0;
      while (ack)
      begin
         @(negedge clk);
         release_cycles++;
      end
      assert (release_cycles == 1)
      else
      begin
         handshake_errors++;
         $display("handshake error in %0s: ack fell %0d cycles after req", name, release_cycles);
      end
      got = first;
   endtask

   task automatic check_result
   (
      input string              name,
      input logic [31:0]        exp_word,
      input logic [2:0]         exp_flags,
      input fpu_pkg::fpu_resp_t got
   );
      assert (got.result == exp_word)
      else
      begin
         mismatches++;
         $display("MISMATCH %0s result expected %08h actual %08h", name, exp_word, got.result);
      end
      // Flag order ovf, uf, inexact
      assert ({got.ovf, got.uf, got.inexact} == exp_flags)
      else
      begin
         mismatches++;
         $display("MISMATCH %0s flags expected %03b actual %03b",
                  name, exp_flags, {got.ovf, got.uf, got.inexact});
      end
   endtask

   task automatic print_summary();
      $display("summary: %0d mismatches, %0d handshake errors, %0d timeouts",
               mismatches, handshake_errors, timeouts);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      fpu_pkg::fpu_req_t  data;
      fpu_pkg::fpu_resp_t got;
      test_vec_t          vec;
      string              name;
      int                 a_int;
      int                 b_int;
      int                 res_int;
      logic [31:0]        exp_word;
      clk       = 1'b0;
      rst_n     = 1'b0;
      req       = 1'b0;
      req_data  = '0;
      lcg_state = 32'd68;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (!ack && resp == '0)
      else
      begin
         handshake_errors++;
         $display("handshake error: ack or resp not cleared after reset");
      end

      // Directed table, hold varies per row
      for (int i = 0; i < $size(vec_table); i++)
      begin
         vec     = vec_table[i];
         name    = $sformatf("%0s", vec.name);
         data.op = vec.op;
         data.a  = vec.a;
         data.b  = vec.b;
         send_request(name, data, i % 5, got);
         check_result(name, vec.result, vec.flags, got);
      end

      // Random integers, always exact in binary32
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         a_int   = draw_operand();
         b_int   = draw_operand();
         data.op = fpu_pkg::fpu_op_e'(i % 3);
         data.a  = int_to_f32(a_int);
         data.b  = int_to_f32(b_int);
         case (data.op)
            fpu_pkg::OP_ADD: res_int = a_int + b_int;
            fpu_pkg::OP_SUB: res_int = a_int - b_int;
            default:         res_int = a_int * b_int;
         endcase
         exp_word = int_to_f32(res_int);
         // Zero product takes the xor of the operand signs
         if (data.op == fpu_pkg::OP_MUL && res_int == 0)
            exp_word[31] = (a_int < 0) ^ (b_int < 0);
         name = $sformatf("rand_%0d", i);
         send_request(name, data, i % 4, got);
         check_result(name, exp_word, 3'b000, got);
      end

      print_summary();
      if (mismatches == 0 && handshake_errors == 0 && timeouts == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Watchdog sized from the test count
   initial
   begin : watchdog
      int limit;
      limit = RESET_CYCLES + CYCLES_PER_TEST * ($size(vec_table) + NUM_RANDOM);
      repeat (limit) @(posedge clk);
      timeouts++;
      $display("timeout: run did not finish within %0d cycles, a handshake is stuck", limit);
      print_summary();
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/fpu_top.sv ====
`default_nettype none

module fpu_top
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req,
   input  fpu_pkg::fpu_req_t  req_data,
   output logic               ack,
   output fpu_pkg::fpu_resp_t resp
);

   // Captured operation and operands
   fpu_pkg::fpu_op_e      op;
   fpu_pkg::fpu_operand_t op_a;
   fpu_pkg::fpu_operand_t op_b;

   // Prenorm results, one per unit
   fpu_pkg::fpu_prenorm_t add_pre;
   fpu_pkg::fpu_prenorm_t mul_pre;

   // Finished result back to the controller
   fpu_pkg::fpu_resp_t    norm_resp;

   // Handshake and operand register
   fpu_ctrl u_fpu_ctrl
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_data  (req_data),
      .norm_resp (norm_resp),
      .ack       (ack),
      .resp      (resp),
      .op        (op),
      .op_a      (op_a),
      .op_b      (op_b)
   );

   // Add and multiply run side by side
   fpu_add u_fpu_add
   (
      .op_a    (op_a),
      .op_b    (op_b),
      .prenorm (add_pre)
   );

   fpu_mult u_fpu_mult
   (
      .op_a    (op_a),
      .op_b    (op_b),
      .prenorm (mul_pre)
   );

   // Pick by op, normalize, round
   fpu_norm u_fpu_norm
   (
      .op      (op),
      .add_pre (add_pre),
      .mul_pre (mul_pre),
      .resp    (norm_resp)
   );

endmodule

`default_nettype wire

// ==== design/fpu_ctrl.sv ====
`default_nettype none

module fpu_ctrl
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req,
   input  fpu_pkg::fpu_req_t     req_data,
   input  fpu_pkg::fpu_resp_t    norm_resp,
   output logic                  ack,
   output fpu_pkg::fpu_resp_t    resp,
   output fpu_pkg::fpu_op_e      op,
   output fpu_pkg::fpu_operand_t op_a,
   output fpu_pkg::fpu_operand_t op_b
);

   // Idle, compute, wait for req low
   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_BUSY,
      ST_DONE
   } state_e;

   state_e            state;
   fpu_pkg::fpu_req_t req_q;

   // Split a binary32 word into sign, exponent, mantissa
   function automatic fpu_pkg::fpu_operand_t unpack
   (
      input logic [fpu_pkg::C_EXP+fpu_pkg::C_MANT:0] word
   );
      fpu_pkg::fpu_operand_t opd;
      opd.sign = word[fpu_pkg::C_EXP+fpu_pkg::C_MANT];
      opd.exp  = word[fpu_pkg::C_MANT +: fpu_pkg::C_EXP];
      // Zero exponent: denormal or zero, both read as zero
      if (opd.exp == '0)
         opd.mant = '0;
      else
         opd.mant = {1'b1, word[fpu_pkg::C_MANT-1:0]};
      return opd;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Handshake FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state <= ST_IDLE;
         ack   <= 1'b0;
         resp  <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (req)
                  state <= ST_BUSY;
            // Datapath settled from req_q, latch the answer
            ST_BUSY:
            begin
               resp  <= norm_resp;
               ack   <= 1'b1;
               state <= ST_DONE;
            end
            // Hold ack and resp until the requester lets go
            ST_DONE:
               if (!req)
               begin
                  ack   <= 1'b0;
                  state <= ST_IDLE;
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // Request capture on acceptance
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && req)
         req_q <= req_data;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Operand unpack
   ////////////////////////////////////////////////////////////////////////////

   assign op = req_q.op;

   always_comb
   begin
      op_a = unpack(req_q.a);
      op_b = unpack(req_q.b);
      // a - b handled as a + (-b)
      if (req_q.op == fpu_pkg::OP_SUB)
         op_b.sign = ~op_b.sign;
   end

endmodule

`default_nettype wire

// ==== design/fpu_norm.sv ====
`default_nettype none

module fpu_norm
(
   input  fpu_pkg::fpu_op_e      op,
   input  fpu_pkg::fpu_prenorm_t add_pre,
   input  fpu_pkg::fpu_prenorm_t mul_pre,
   output fpu_pkg::fpu_resp_t    resp
);

   // Selected prenorm result
   fpu_pkg::fpu_prenorm_t              sel;
   logic                               zero_sign;

   // Leading-one normalization
   int                                 lz;
   logic [fpu_pkg::C_MANT_PRENORM-1:0] mant_norm;
   int                                 exp_norm;

   // Rounding
   logic [fpu_pkg::C_MANT:0]           mant_keep;
   logic                               guard;
   logic                               round_bit;
   logic                               sticky;
   logic                               round_up;
   logic [fpu_pkg::C_MANT+1:0]         mant_rnd;
   logic [fpu_pkg::C_MANT-1:0]         frac;
   int                                 exp_final;

   assign sel       = (op == fpu_pkg::OP_MUL) ? mul_pre : add_pre;
   // Exact zero: plus for add/sub, product sign for mult
   assign zero_sign = (op == fpu_pkg::OP_MUL) ? mul_pre.sign : 1'b0;

   ////////////////////////////////////////////////////////////////////////////
   // Leading one to bit 47
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      // Highest set bit wins, 48 means all zero
      lz = fpu_pkg::C_MANT_PRENORM;
      for (int i = 0; i < fpu_pkg::C_MANT_PRENORM; i++)
      begin
         if (sel.mant[i])
            lz = fpu_pkg::C_MANT_PRENORM - 1 - i;
      end
   end

   assign mant_norm = sel.mant << lz;

   // Input hidden bit sits at 46, so one left shift is free
   assign exp_norm = int'($signed(sel.exp)) + 1 - lz;

   ////////////////////////////////////////////////////////////////////////////
   // Round to nearest even
   ////////////////////////////////////////////////////////////////////////////

   // Hidden bit plus 23 fraction bits
   assign mant_keep = mant_norm[fpu_pkg::C_MANT_PRENORM-1 -: fpu_pkg::C_MANT+1];
   assign guard     = mant_norm[fpu_pkg::C_MANT_PRENORM-fpu_pkg::C_MANT-2];
   assign round_bit = mant_norm[fpu_pkg::C_MANT_PRENORM-fpu_pkg::C_MANT-3];
   assign sticky    = |mant_norm[fpu_pkg::C_MANT_PRENORM-fpu_pkg::C_MANT-4:0];

   // Ties go to the even LSB
   assign round_up = guard & (round_bit | sticky | mant_keep[0]);
   assign mant_rnd = {1'b0, mant_keep} + round_up;

   // Carry out of rounding leaves 10.000..., shift down once
   always_comb
   begin
      if (mant_rnd[fpu_pkg::C_MANT+1])
      begin
         frac      = mant_rnd[fpu_pkg::C_MANT:1];
         exp_final = exp_norm + 1;
      end
      else
      begin
         frac      = mant_rnd[fpu_pkg::C_MANT-1:0];
         exp_final = exp_norm;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Classification and flags
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      resp = '0;
      if (sel.mant == '0)
      begin
         // Exact zero, nothing lost
         resp.result[fpu_pkg::C_EXP+fpu_pkg::C_MANT] = zero_sign;
      end
      else if (exp_final >= (2 ** fpu_pkg::C_EXP) - 1)
      begin
         // Overflow to signed infinity
         resp.result  = {sel.sign, {fpu_pkg::C_EXP{1'b1}}, {fpu_pkg::C_MANT{1'b0}}};
         resp.ovf     = 1'b1;
         resp.inexact = 1'b1;
      end
      else if (exp_final <= 0)
      begin
         // Flush to signed zero
         resp.result[fpu_pkg::C_EXP+fpu_pkg::C_MANT] = sel.sign;
         resp.uf      = 1'b1;
         resp.inexact = 1'b1;
      end
      else
      begin
         resp.result  = {sel.sign, exp_final[fpu_pkg::C_EXP-1:0], frac};
         resp.inexact = guard | round_bit | sticky;
      end
   end

endmodule

`default_nettype wire

// ==== design/fpu_mult.sv ====
`default_nettype none

module fpu_mult
(
   input  fpu_pkg::fpu_operand_t op_a,
   input  fpu_pkg::fpu_operand_t op_b,
   output fpu_pkg::fpu_prenorm_t prenorm
);

   // Biased exponents widened to prenorm width
   logic [fpu_pkg::C_EXP_PRENORM-1:0]  exp_a_ext;
   logic [fpu_pkg::C_EXP_PRENORM-1:0]  exp_b_ext;
   logic [fpu_pkg::C_EXP_PRENORM-1:0]  exp_sum;

   // Full mantissa product
   logic [fpu_pkg::C_MANT_PRENORM-1:0] product;

   ////////////////////////////////////////////////////////////////////////////
   // Exponent
   ////////////////////////////////////////////////////////////////////////////

   assign exp_a_ext = {{(fpu_pkg::C_EXP_PRENORM - fpu_pkg::C_EXP){1'b0}}, op_a.exp};
   assign exp_b_ext = {{(fpu_pkg::C_EXP_PRENORM - fpu_pkg::C_EXP){1'b0}}, op_b.exp};

   // Sum carries the bias twice so one is taken off
   // wraps to a negative value on deep underflow
   assign exp_sum = exp_a_ext + exp_b_ext - fpu_pkg::C_BIAS[fpu_pkg::C_EXP_PRENORM-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // Mantissa
   ////////////////////////////////////////////////////////////////////////////

   // 1.23 x 1.23 gives 2.46 with the adder's binary point
   assign product = op_a.mant * op_b.mant;

   assign prenorm.sign = op_a.sign ^ op_b.sign;
   assign prenorm.exp  = exp_sum;
   assign prenorm.mant = product;

endmodule

`default_nettype wire

// ==== design/fpu_add.sv ====
`default_nettype none

module fpu_add
(
   input  fpu_pkg::fpu_operand_t op_a,
   input  fpu_pkg::fpu_operand_t op_b,
   output fpu_pkg::fpu_prenorm_t prenorm
);

   // Exponent compare
   logic                               exp_a_gt_b;
   logic                               exp_equal;
   logic [fpu_pkg::C_EXP-1:0]          exp_diff;
   logic [fpu_pkg::C_EXP-1:0]          exp_max;

   // Alignment
   logic                               mant_a_gt_b;
   logic [fpu_pkg::C_MANT_SHIFTIN-1:0] shift_in;
   logic [fpu_pkg::C_MANT_SHIFTED-1:0] shifted;
   logic [fpu_pkg::C_MANT_SHIFTED-1:0] unshifted;
   logic                               sticky;

   // Main adder
   logic                               subtract;
   logic                               inv_shifted;
   logic                               inv_unshifted;
   logic [fpu_pkg::C_MANT_ADDIN-1:0]   add_in_a;
   logic [fpu_pkg::C_MANT_ADDIN-1:0]   add_in_b;
   logic [fpu_pkg::C_MANT_ADDOUT-1:0]  add_out;
   logic                               sign_res;

   ////////////////////////////////////////////////////////////////////////////
   // Exponent alignment
   ////////////////////////////////////////////////////////////////////////////

   assign exp_a_gt_b = op_a.exp > op_b.exp;
   assign exp_equal  = (exp_diff == '0);

   always_comb
   begin
      if (exp_a_gt_b)
      begin
         exp_diff = op_a.exp - op_b.exp;
         exp_max  = op_a.exp;
      end
      else
      begin
         exp_diff = op_b.exp - op_a.exp;
         exp_max  = op_b.exp;
      end
   end

   // Smaller exponent goes through the shifter
   assign mant_a_gt_b = op_a.mant > op_b.mant;
   assign unshifted   = {(exp_a_gt_b ? op_a.mant : op_b.mant), 3'b000};
   assign shift_in    = {(exp_a_gt_b ? op_b.mant : op_a.mant), 2'b00};

   // Sticky is the OR of everything pushed past the round bit
   always_comb
   begin
      if (exp_diff >= fpu_pkg::C_MANT_SHIFTIN)
         sticky = |shift_in;
      else
         sticky = |(shift_in << (fpu_pkg::C_MANT_SHIFTIN - exp_diff));
   end

   assign shifted = {(shift_in >> exp_diff), sticky};

   ////////////////////////////////////////////////////////////////////////////
   // Mantissa add / subtract
   ////////////////////////////////////////////////////////////////////////////

   // Effective subtraction when signs differ
   assign subtract = op_a.sign ^ op_b.sign;

   // Invert whichever magnitude is smaller
   // unshifted is only smaller on equal exponents
   assign inv_unshifted = subtract & exp_equal & mant_a_gt_b;
   assign inv_shifted   = subtract & ~inv_unshifted;

   assign add_in_a = inv_shifted   ? ~shifted   : shifted;
   assign add_in_b = inv_unshifted ? ~unshifted : unshifted;

   // Carry-in completes the two's complement
   assign add_out = add_in_a + add_in_b + subtract;

   ////////////////////////////////////////////////////////////////////////////
   // Result sign and output
   ////////////////////////////////////////////////////////////////////////////

   // Sign follows the larger magnitude
   always_comb
   begin
      if (exp_a_gt_b)
         sign_res = op_a.sign;
      else if (exp_equal && mant_a_gt_b)
         sign_res = op_a.sign;
      else
         sign_res = op_b.sign;
   end

   assign prenorm.sign = sign_res;
   assign prenorm.exp  = {{(fpu_pkg::C_EXP_PRENORM - fpu_pkg::C_EXP){1'b0}}, exp_max};

   // Carry is meaningless on subtraction, drop it
   // sum lands with its hidden bit at 46, zeros below
   assign prenorm.mant =
      {
         add_out[fpu_pkg::C_MANT_ADDOUT-1] & ~subtract,
         add_out[fpu_pkg::C_MANT_ADDOUT-2:0],
         {(fpu_pkg::C_MANT_PRENORM - fpu_pkg::C_MANT_ADDOUT){1'b0}}
      };

endmodule

`default_nettype wire

// ==== design/fpu_pkg.sv ====
`default_nettype none

package fpu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Format widths
   ////////////////////////////////////////////////////////////////////////////

   // Binary32 fields
   localparam int C_EXP  = 8;
   localparam int C_MANT = 23;
   localparam int C_BIAS = 127;

   // Prenorm exponent is signed, two guard bits for ovf/uf
   localparam int C_EXP_PRENORM  = 10;
   // Carry at bit 47, hidden bit at 46, then fraction and GRS
   localparam int C_MANT_PRENORM = 48;

   // Adder internals
   // Mantissa plus guard and round
   localparam int C_MANT_SHIFTIN = C_MANT + 3;
   // Shifted operand with sticky appended
   localparam int C_MANT_SHIFTED = C_MANT + 4;
   localparam int C_MANT_ADDIN   = C_MANT + 4;
   // One extra bit for the carry out
   localparam int C_MANT_ADDOUT  = C_MANT + 5;

   ////////////////////////////////////////////////////////////////////////////
   // Operation codes and bundles
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0]
   {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2
   } fpu_op_e;

   // One request from the requester
   typedef struct packed
   {
      fpu_op_e                 op;
      logic [C_EXP+C_MANT:0]   a;
      logic [C_EXP+C_MANT:0]   b;
   } fpu_req_t;

   // Operand split into fields, hidden bit included
   typedef struct packed
   {
      logic                    sign;
      logic [C_EXP-1:0]        exp;
      logic [C_MANT:0]         mant;
   } fpu_operand_t;

   // Result ahead of normalization
   typedef struct packed
   {
      logic                            sign;
      logic signed [C_EXP_PRENORM-1:0] exp;
      logic [C_MANT_PRENORM-1:0]       mant;
   } fpu_prenorm_t;

   // Response word and exception flags
   typedef struct packed
   {
      logic [C_EXP+C_MANT:0]   result;
      logic                    ovf;
      logic                    uf;
      logic                    inexact;
   } fpu_resp_t;

endpackage

`default_nettype wire
